/* files.f */
design/rv32i_pkg.sv
design/fetch_stage.sv
design/regfile.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_stage.sv
design/cpu_top.sv
test/tb_cpu.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_cpu -f files.f -o Vtb_cpu
	./obj_dir/Vtb_cpu | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;

   localparam int          timeout_cycles = 200;
   localparam logic [31:0] nop_instr      = 32'h0000_0013;
   localparam logic [6:0]  op_imm         = 7'b0010011;
   localparam logic [6:0]  op_load        = 7'b0000011;

   logic        clk;
   logic        rst_i;
   logic [31:0] imem_addr_o;
   logic [31:0] imem_rdata_i;
   logic [31:0] dmem_addr_o;
   logic [31:0] dmem_wdata_o;
   logic        dmem_read_o;
   logic        dmem_write_o;
   logic [31:0] dmem_rdata_i;

   logic [31:0] imem [0:1023];
   int          pc_idx;

   // expected stores of the running test in program order
   logic [31:0] exp_addr [0:63];
   logic [31:0] exp_data [0:63];
   int          n_exp = 0;
   int          seen = 0;
   logic        head_ok;
   logic [31:0] head_addr;
   logic [31:0] head_data;

   int errors = 0;
   int tests_run = 0;
   int tests_failed = 0;

   cpu_top uut (
      .clk          (clk),
      .rst_i        (rst_i),
      .imem_addr_o  (imem_addr_o),
      .imem_rdata_i (imem_rdata_i),
      .dmem_addr_o  (dmem_addr_o),
      .dmem_wdata_o (dmem_wdata_o),
      .dmem_read_o  (dmem_read_o),
      .dmem_write_o (dmem_write_o),
      .dmem_rdata_i (dmem_rdata_i)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   assign imem_rdata_i = imem[imem_addr_o[11:2]];
   // data memory reads back a pattern of the full address
   assign dmem_rdata_i = dmem_addr_o ^ 32'h5a5a_0000;

   assign head_ok   = seen < n_exp;
   assign head_addr = exp_addr[seen[5:0]];
   assign head_data = exp_data[seen[5:0]];

   always @(posedge clk) begin
      if (rst_i) begin
         seen <= 0;
      end else if (dmem_write_o) begin
         seen <= seen + 1;
      end
   end

   store_expected: assert property (@(posedge clk) disable iff (rst_i) dmem_write_o |-> head_ok)
      else begin
         errors++;
         $display("unexpected store to %h with data %h",
                  $sampled(dmem_addr_o), $sampled(dmem_wdata_o));
      end

   store_addr: assert property (@(posedge clk) disable iff (rst_i)
                                dmem_write_o && head_ok |-> dmem_addr_o == head_addr)
      else begin
         errors++;
         $display("CHECK FAILED dmem_addr_o got %h expected %h",
                  $sampled(dmem_addr_o), $sampled(head_addr));
      end

   store_data: assert property (@(posedge clk) disable iff (rst_i)
                                dmem_write_o && head_ok |-> dmem_wdata_o == head_data)
      else begin
         errors++;
         $display("CHECK FAILED dmem_wdata_o got %h expected %h",
                  $sampled(dmem_wdata_o), $sampled(head_data));
      end

   function automatic logic [31:0] sign_extend12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, 7'b0110111};
   endfunction

   task automatic emit(input logic [31:0] instr);
      imem[pc_idx] = instr;
      pc_idx++;
   endtask

   // addi sign-extends its immediate so the upper part is rounded
   task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
      logic [31:0] rounded;
      rounded = value + 32'h800;
      emit(u_type(rounded[31:12], rd));
      emit(nop_instr);
      emit(nop_instr);
      emit(i_type(value[11:0], rd, 3'b000, rd, op_imm));
      emit(nop_instr);
      emit(nop_instr);
   endtask

   task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
      exp_addr[n_exp] = addr;
      exp_data[n_exp] = data;
      n_exp++;
   endtask

   task automatic begin_test();
      @(negedge clk);
      rst_i = 1'b1;
      for (int i = 0; i < 1024; i++) begin
         imem[i] = nop_instr;
      end
      pc_idx = 0;
      n_exp  = 0;
   endtask

   task automatic release_reset();
      repeat (3) @(negedge clk);
      rst_i = 1'b0;
   endtask

   task automatic check_eq(input string sig, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("CHECK FAILED %s got %h expected %h", sig, got, exp);
      end
   endtask

   task automatic wait_stores();
      int cycles;
      cycles = 0;
      while (seen < n_exp && cycles < timeout_cycles) begin
         @(negedge clk);
         cycles++;
      end
      assert (seen >= n_exp) else begin
         errors++;
         $display("timeout with only %0d of %0d expected stores seen", seen, n_exp);
      end
   endtask

   task automatic wait_fetch(input logic [31:0] addr, output int cycles);
      cycles = 0;
      while (imem_addr_o !== addr && cycles < timeout_cycles) begin
         @(negedge clk);
         cycles++;
      end
      assert (imem_addr_o === addr) else begin
         errors++;
         $display("timeout waiting for a fetch from %h", addr);
      end
   endtask

   task automatic wait_read(input logic [31:0] addr);
      int cycles;
      cycles = 0;
      while (dmem_read_o !== 1'b1 && cycles < timeout_cycles) begin
         @(negedge clk);
         cycles++;
      end
      assert (dmem_read_o === 1'b1) else begin
         errors++;
         $display("timeout waiting for the load to read data memory");
      end
      check_eq("dmem_addr_o", dmem_addr_o, addr);
   endtask

   task automatic report_test(input string name, input int err_before);
      tests_run++;
      if (errors == err_before) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: FAILED", name);
      end
   endtask

   task automatic test_reset_fetch();
      int err_before;
      err_before = errors;
      begin_test();
      release_reset();
      for (int k = 0; k < 8; k++) begin
         check_eq("imem_addr_o", imem_addr_o, 32'(4 * k));
         check_eq("dmem_read_o", {31'd0, dmem_read_o}, 32'd0);
         check_eq("dmem_write_o", {31'd0, dmem_write_o}, 32'd0);
         @(negedge clk);
      end
      report_test("reset and fetch", err_before);
   endtask

   task automatic test_alu();
      logic [31:0] a;
      logic [31:0] b;
      logic [19:0] k;
      logic [11:0] im1;
      logic [11:0] im2;
      logic [11:0] im3;
      logic [31:0] res [0:9];
      int          err_before;
      err_before = errors;
      a   = $urandom;
      b   = $urandom;
      k   = 20'($urandom);
      im1 = 12'($urandom);
      im2 = 12'($urandom);
      im3 = 12'($urandom);
      res[0] = {k, 12'd0};
      res[1] = a + sign_extend12(im1);
      res[2] = a & sign_extend12(im2);
      res[3] = a | sign_extend12(im3);
      res[4] = a + b;
      res[5] = a - b;
      res[6] = a & b;
      res[7] = a | b;
      res[8] = a ^ b;
      // a negative a is below any non-negative b
      res[9] = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
      begin_test();
      load_const(5'd1, a);
      load_const(5'd2, b);
      emit(u_type(k, 5'd3));
      emit(i_type(im1, 5'd1, 3'b000, 5'd4, op_imm));
      emit(i_type(im2, 5'd1, 3'b111, 5'd5, op_imm));
      emit(i_type(im3, 5'd1, 3'b110, 5'd6, op_imm));
      emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd7));
      emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd8));
      emit(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd9));
      emit(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd10));
      emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd11));
      emit(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd12));
      emit(nop_instr);
      emit(nop_instr);
      for (int i = 0; i < 10; i++) begin
         emit(s_type(12'(256 + 4 * i), 5'(i + 3), 5'd0));
         expect_store(32'(256 + 4 * i), res[i]);
      end
      release_reset();
      wait_stores();
      report_test("alu", err_before);
   endtask

   task automatic test_load();
      logic [31:0] addr;
      int          err_before;
      err_before = errors;
      addr = $urandom & 32'hffff_fffc;
      begin_test();
      load_const(5'd1, addr);
      emit(i_type(12'd0, 5'd1, 3'b010, 5'd2, op_load));
      emit(nop_instr);
      emit(nop_instr);
      emit(s_type(12'h200, 5'd2, 5'd0));
      expect_store(32'h200, addr ^ 32'h5a5a_0000);
      release_reset();
      wait_read(addr);
      wait_stores();
      report_test("load", err_before);
   endtask

   task automatic test_branch_taken();
      logic [11:0] v;
      int          br_idx;
      int          cycles;
      int          err_before;
      err_before = errors;
      v = 12'($urandom);
      begin_test();
      emit(i_type(v, 5'd0, 3'b000, 5'd1, op_imm));
      emit(i_type(v, 5'd0, 3'b000, 5'd2, op_imm));
      emit(nop_instr);
      emit(nop_instr);
      br_idx = pc_idx;
      emit(b_type(13'd32, 5'd2, 5'd1, 3'b000));
      // wrong path stores squashed by the redirect
      emit(s_type(12'h310, 5'd1, 5'd0));
      emit(s_type(12'h314, 5'd1, 5'd0));
      emit(s_type(12'h318, 5'd1, 5'd0));
      pc_idx = br_idx + 8;
      emit(s_type(12'h300, 5'd1, 5'd0));
      expect_store(32'h300, sign_extend12(v));
      release_reset();
      wait_fetch(32'(4 * br_idx), cycles);
      wait_fetch(32'(4 * br_idx + 32), cycles);
      assert (cycles == 4) else begin
         errors++;
         $display("branch redirect reached the target after %0d cycles, not 4", cycles);
      end
      wait_stores();
      report_test("beq taken", err_before);
   endtask

   task automatic test_branch_not_taken();
      logic [11:0] v;
      logic [11:0] w;
      int          err_before;
      err_before = errors;
      v = 12'($urandom);
      w = 12'($urandom);
      begin_test();
      emit(i_type(v, 5'd0, 3'b000, 5'd1, op_imm));
      emit(i_type(v, 5'd0, 3'b000, 5'd2, op_imm));
      emit(i_type(w, 5'd0, 3'b000, 5'd3, op_imm));
      emit(nop_instr);
      emit(nop_instr);
      emit(b_type(13'd12, 5'd2, 5'd1, 3'b001));
      emit(s_type(12'h400, 5'd1, 5'd0));
      emit(nop_instr);
      emit(s_type(12'h404, 5'd3, 5'd0));
      expect_store(32'h400, sign_extend12(v));
      expect_store(32'h404, sign_extend12(w));
      release_reset();
      wait_stores();
      report_test("bne not taken", err_before);
   endtask

   initial begin
      rst_i = 1'b1;
      void'($urandom(24650));
      test_reset_fetch();
      test_alu();
      test_load();
      test_branch_taken();
      test_branch_not_taken();
      $display("tests run: %0d, failed: %0d, check errors: %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* design/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
   input  logic                       clk,
   input  logic                       rst_i,
   output logic [rv32i_pkg::xlen-1:0] imem_addr_o,
   input  logic [rv32i_pkg::xlen-1:0] imem_rdata_i,
   output logic [rv32i_pkg::xlen-1:0] dmem_addr_o,
   output logic [rv32i_pkg::xlen-1:0] dmem_wdata_o,
   output logic                       dmem_read_o,
   output logic                       dmem_write_o,
   input  logic [rv32i_pkg::xlen-1:0] dmem_rdata_i
);

   // redirect from memory stage
   logic                       pcmux_sel;
   logic [rv32i_pkg::xlen-1:0] branch_target;

   // fetch to decode
   logic                       if_valid;
   logic [rv32i_pkg::xlen-1:0] if_pc;
   logic [rv32i_pkg::xlen-1:0] if_instr;

   // register file ports
   logic [4:0]                 rs1_addr;
   logic [4:0]                 rs2_addr;
   logic [rv32i_pkg::xlen-1:0] rs1_data;
   logic [rv32i_pkg::xlen-1:0] rs2_data;
   logic                       wb_we;
   logic [4:0]                 wb_rd;
   logic [rv32i_pkg::xlen-1:0] wb_data;

   // decode to execute
   logic                       id_valid;
   logic [rv32i_pkg::xlen-1:0] id_pc;
   logic [rv32i_pkg::xlen-1:0] id_rs1_val;
   logic [rv32i_pkg::xlen-1:0] id_rs2_val;
   logic [rv32i_pkg::xlen-1:0] id_imm;
   logic [4:0]                 id_rd;
   rv32i_pkg::opcode_e         id_opcode;
   logic [2:0]                 id_funct3;
   rv32i_pkg::alu_op_e         id_alu_op;
   logic                       id_use_imm;
   logic                       id_reg_write;

   // execute to memory
   logic                       ex_valid;
   rv32i_pkg::opcode_e         ex_opcode;
   logic [rv32i_pkg::xlen-1:0] ex_alu_out;
   logic                       ex_br_en;
   logic [rv32i_pkg::xlen-1:0] ex_rs2_val;
   logic [4:0]                 ex_rd;
   logic                       ex_reg_write;

   fetch_stage u_fetch (
      .clk             (clk),
      .rst_i           (rst_i),
      .pcmux_sel_i     (pcmux_sel),
      .branch_target_i (branch_target),
      .imem_addr_o     (imem_addr_o),
      .imem_rdata_i    (imem_rdata_i),
      .valid_o         (if_valid),
      .pc_o            (if_pc),
      .instr_o         (if_instr)
   );

   regfile u_regfile (
      .clk        (clk),
      .rst_i      (rst_i),
      .rs1_addr_i (rs1_addr),
      .rs2_addr_i (rs2_addr),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data),
      .we_i       (wb_we),
      .rd_i       (wb_rd),
      .wdata_i    (wb_data)
   );

   decode_stage u_decode (
      .clk         (clk),
      .rst_i       (rst_i),
      .flush_i     (pcmux_sel),
      .valid_i     (if_valid),
      .pc_i        (if_pc),
      .instr_i     (if_instr),
      .rs1_addr_o  (rs1_addr),
      .rs2_addr_o  (rs2_addr),
      .rs1_data_i  (rs1_data),
      .rs2_data_i  (rs2_data),
      .valid_o     (id_valid),
      .pc_o        (id_pc),
      .rs1_val_o   (id_rs1_val),
      .rs2_val_o   (id_rs2_val),
      .imm_o       (id_imm),
      .rd_o        (id_rd),
      .opcode_o    (id_opcode),
      .funct3_o    (id_funct3),
      .alu_op_o    (id_alu_op),
      .use_imm_o   (id_use_imm),
      .reg_write_o (id_reg_write)
   );

   execute_stage u_execute (
      .clk         (clk),
      .rst_i       (rst_i),
      .flush_i     (pcmux_sel),
      .valid_i     (id_valid),
      .pc_i        (id_pc),
      .rs1_val_i   (id_rs1_val),
      .rs2_val_i   (id_rs2_val),
      .imm_i       (id_imm),
      .rd_i        (id_rd),
      .opcode_i    (id_opcode),
      .funct3_i    (id_funct3),
      .alu_op_i    (id_alu_op),
      .use_imm_i   (id_use_imm),
      .reg_write_i (id_reg_write),
      .valid_o     (ex_valid),
      .opcode_o    (ex_opcode),
      .alu_out_o   (ex_alu_out),
      .br_en_o     (ex_br_en),
      .rs2_val_o   (ex_rs2_val),
      .rd_o        (ex_rd),
      .reg_write_o (ex_reg_write)
   );

   mem_stage u_mem (
      .clk             (clk),
      .rst_i           (rst_i),
      .valid_i         (ex_valid),
      .opcode_i        (ex_opcode),
      .alu_out_i       (ex_alu_out),
      .br_en_i         (ex_br_en),
      .rs2_val_i       (ex_rs2_val),
      .rd_i            (ex_rd),
      .reg_write_i     (ex_reg_write),
      .pcmux_sel_o     (pcmux_sel),
      .branch_target_o (branch_target),
      .dmem_addr_o     (dmem_addr_o),
      .dmem_wdata_o    (dmem_wdata_o),
      .dmem_read_o     (dmem_read_o),
      .dmem_write_o    (dmem_write_o),
      .dmem_rdata_i    (dmem_rdata_i),
      .wb_we_o         (wb_we),
      .wb_rd_o         (wb_rd),
      .wb_data_o       (wb_data)
   );

endmodule

/* design/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
   input  logic                       clk,
   input  logic                       rst_i,
   input  logic                       valid_i,
   input  rv32i_pkg::opcode_e         opcode_i,
   input  logic [rv32i_pkg::xlen-1:0] alu_out_i,
   input  logic                       br_en_i,
   input  logic [rv32i_pkg::xlen-1:0] rs2_val_i,
   input  logic [4:0]                 rd_i,
   input  logic                       reg_write_i,
   output logic                       pcmux_sel_o,
   output logic [rv32i_pkg::xlen-1:0] branch_target_o,
   output logic [rv32i_pkg::xlen-1:0] dmem_addr_o,
   output logic [rv32i_pkg::xlen-1:0] dmem_wdata_o,
   output logic                       dmem_read_o,
   output logic                       dmem_write_o,
   input  logic [rv32i_pkg::xlen-1:0] dmem_rdata_i,
   output logic                       wb_we_o,
   output logic [4:0]                 wb_rd_o,
   output logic [rv32i_pkg::xlen-1:0] wb_data_o
);

   logic is_load;
   logic is_store;

   assign is_load  = valid_i && (opcode_i == rv32i_pkg::op_load);
   assign is_store = valid_i && (opcode_i == rv32i_pkg::op_store);

   // alu_out holds the effective address for loads and stores
   assign dmem_addr_o  = alu_out_i;
   assign dmem_wdata_o = rs2_val_i;
   assign dmem_read_o  = is_load;
   assign dmem_write_o = is_store;

   // for a branch alu_out is the target
   assign pcmux_sel_o     = valid_i && br_en_i && (opcode_i == rv32i_pkg::op_br);
   assign branch_target_o = alu_out_i;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wb_we_o <= 1'b0;
      end else begin
         wb_we_o <= valid_i && reg_write_i;
      end
   end

   always_ff @(posedge clk) begin
      wb_rd_o   <= rd_i;
      wb_data_o <= is_load ? dmem_rdata_i : alu_out_i;
   end

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
   input  logic                       clk,
   input  logic                       rst_i,
   input  logic                       flush_i,
   input  logic                       valid_i,
   input  logic [rv32i_pkg::xlen-1:0] pc_i,
   input  logic [rv32i_pkg::xlen-1:0] rs1_val_i,
   input  logic [rv32i_pkg::xlen-1:0] rs2_val_i,
   input  logic [rv32i_pkg::xlen-1:0] imm_i,
   input  logic [4:0]                 rd_i,
   input  rv32i_pkg::opcode_e         opcode_i,
   input  logic [2:0]                 funct3_i,
   input  rv32i_pkg::alu_op_e         alu_op_i,
   input  logic                       use_imm_i,
   input  logic                       reg_write_i,
   output logic                       valid_o,
   output rv32i_pkg::opcode_e         opcode_o,
   output logic [rv32i_pkg::xlen-1:0] alu_out_o,
   output logic                       br_en_o,
   output logic [rv32i_pkg::xlen-1:0] rs2_val_o,
   output logic [4:0]                 rd_o,
   output logic                       reg_write_o
);

   logic [rv32i_pkg::xlen-1:0] op_a;
   logic [rv32i_pkg::xlen-1:0] op_b;
   logic [rv32i_pkg::xlen-1:0] alu_res;
   logic                       br_cond;

   // branches reuse the adder for pc + b_imm
   always_comb begin
      if (opcode_i == rv32i_pkg::op_br) begin
         op_a = pc_i;
         op_b = imm_i;
      end else begin
         op_a = rs1_val_i;
         op_b = use_imm_i ? imm_i : rs2_val_i;
      end
   end

   always_comb begin
      case (alu_op_i)
         rv32i_pkg::alu_add:    alu_res = op_a + op_b;
         rv32i_pkg::alu_sub:    alu_res = op_a - op_b;
         rv32i_pkg::alu_and:    alu_res = op_a & op_b;
         rv32i_pkg::alu_or:     alu_res = op_a | op_b;
         rv32i_pkg::alu_xor:    alu_res = op_a ^ op_b;
         rv32i_pkg::alu_slt:    alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
         rv32i_pkg::alu_pass_b: alu_res = op_b;
         default:               alu_res = op_a + op_b;
      endcase
   end

   always_comb begin
      case (funct3_i)
         rv32i_pkg::funct3_beq: br_cond = (rs1_val_i == rs2_val_i);
         rv32i_pkg::funct3_bne: br_cond = (rs1_val_i != rs2_val_i);
         default:               br_cond = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i || flush_i) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= valid_i;
      end
   end

   always_ff @(posedge clk) begin
      opcode_o    <= opcode_i;
      alu_out_o   <= alu_res;
      br_en_o     <= br_cond;
      rs2_val_o   <= rs2_val_i;
      rd_o        <= rd_i;
      reg_write_o <= reg_write_i;
   end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
   input  logic                       clk,
   input  logic                       rst_i,
   input  logic                       flush_i,
   input  logic                       valid_i,
   input  logic [rv32i_pkg::xlen-1:0] pc_i,
   input  logic [rv32i_pkg::xlen-1:0] instr_i,
   output logic [4:0]                 rs1_addr_o,
   output logic [4:0]                 rs2_addr_o,
   input  logic [rv32i_pkg::xlen-1:0] rs1_data_i,
   input  logic [rv32i_pkg::xlen-1:0] rs2_data_i,
   output logic                       valid_o,
   output logic [rv32i_pkg::xlen-1:0] pc_o,
   output logic [rv32i_pkg::xlen-1:0] rs1_val_o,
   output logic [rv32i_pkg::xlen-1:0] rs2_val_o,
   output logic [rv32i_pkg::xlen-1:0] imm_o,
   output logic [4:0]                 rd_o,
   output rv32i_pkg::opcode_e         opcode_o,
   output logic [2:0]                 funct3_o,
   output rv32i_pkg::alu_op_e         alu_op_o,
   output logic                       use_imm_o,
   output logic                       reg_write_o
);

   logic [6:0]                 opcode;
   logic [2:0]                 funct3;
   logic                       funct7_b5;
   logic [rv32i_pkg::xlen-1:0] i_imm;
   logic [rv32i_pkg::xlen-1:0] s_imm;
   logic [rv32i_pkg::xlen-1:0] b_imm;
   logic [rv32i_pkg::xlen-1:0] u_imm;
   logic [rv32i_pkg::xlen-1:0] imm;
   rv32i_pkg::alu_op_e         alu_op;
   logic                       use_imm;
   logic                       reg_write;
   logic                       legal;

   assign opcode     = instr_i[6:0];
   assign funct3     = instr_i[14:12];
   assign funct7_b5  = instr_i[30];
   assign rs1_addr_o = instr_i[19:15];
   assign rs2_addr_o = instr_i[24:20];

   assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
   assign s_imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
   assign b_imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
   assign u_imm = {instr_i[31:12], 12'd0};

   always_comb begin
      legal     = 1'b1;
      imm       = i_imm;
      alu_op    = rv32i_pkg::alu_add;
      use_imm   = 1'b1;
      reg_write = 1'b0;
      case (opcode)
         rv32i_pkg::op_lui: begin
            imm       = u_imm;
            alu_op    = rv32i_pkg::alu_pass_b;
            reg_write = 1'b1;
         end
         rv32i_pkg::op_imm: begin
            reg_write = 1'b1;
            case (funct3)
               3'b000:  alu_op = rv32i_pkg::alu_add;
               3'b111:  alu_op = rv32i_pkg::alu_and;
               3'b110:  alu_op = rv32i_pkg::alu_or;
               default: legal = 1'b0;
            endcase
         end
         rv32i_pkg::op_reg: begin
            use_imm   = 1'b0;
            reg_write = 1'b1;
            case ({funct7_b5, funct3})
               4'b0000: alu_op = rv32i_pkg::alu_add;
               4'b1000: alu_op = rv32i_pkg::alu_sub;
               4'b0111: alu_op = rv32i_pkg::alu_and;
               4'b0110: alu_op = rv32i_pkg::alu_or;
               4'b0100: alu_op = rv32i_pkg::alu_xor;
               4'b0010: alu_op = rv32i_pkg::alu_slt;
               default: legal = 1'b0;
            endcase
         end
         rv32i_pkg::op_load: begin
            // word access only
            reg_write = 1'b1;
            legal     = (funct3 == 3'b010);
         end
         rv32i_pkg::op_store: begin
            imm   = s_imm;
            legal = (funct3 == 3'b010);
         end
         rv32i_pkg::op_br: begin
            imm   = b_imm;
            legal = (funct3 == rv32i_pkg::funct3_beq) || (funct3 == rv32i_pkg::funct3_bne);
         end
         default: legal = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i || flush_i) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= valid_i && legal;
      end
   end

   always_ff @(posedge clk) begin
      pc_o        <= pc_i;
      rs1_val_o   <= rs1_data_i;
      rs2_val_o   <= rs2_data_i;
      imm_o       <= imm;
      rd_o        <= instr_i[11:7];
      opcode_o    <= rv32i_pkg::opcode_e'(opcode);
      funct3_o    <= funct3;
      alu_op_o    <= alu_op;
      use_imm_o   <= use_imm;
      reg_write_o <= reg_write;
   end

endmodule

/* design/regfile.sv */
`timescale 1ns/1ps

module regfile (
   input  logic                       clk,
   input  logic                       rst_i,
   input  logic [4:0]                 rs1_addr_i,
   input  logic [4:0]                 rs2_addr_i,
   output logic [rv32i_pkg::xlen-1:0] rs1_data_o,
   output logic [rv32i_pkg::xlen-1:0] rs2_data_o,
   input  logic                       we_i,
   input  logic [4:0]                 rd_i,
   input  logic [rv32i_pkg::xlen-1:0] wdata_i
);

   // x0 has no storage
   logic [rv32i_pkg::xlen-1:0] regs [1:31];

   always_ff @(posedge clk) begin
      if (rst_i) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && rd_i != 5'd0) begin
         regs[rd_i] <= wdata_i;
      end
   end

   // writeback data bypasses to decode in the same cycle
   always_comb begin
      if (rs1_addr_i == 5'd0) begin
         rs1_data_o = '0;
      end else if (we_i && rd_i == rs1_addr_i) begin
         rs1_data_o = wdata_i;
      end else begin
         rs1_data_o = regs[rs1_addr_i];
      end
   end

   always_comb begin
      if (rs2_addr_i == 5'd0) begin
         rs2_data_o = '0;
      end else if (we_i && rd_i == rs2_addr_i) begin
         rs2_data_o = wdata_i;
      end else begin
         rs2_data_o = regs[rs2_addr_i];
      end
   end

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
   input  logic                       clk,
   input  logic                       rst_i,
   input  logic                       pcmux_sel_i,
   input  logic [rv32i_pkg::xlen-1:0] branch_target_i,
   output logic [rv32i_pkg::xlen-1:0] imem_addr_o,
   input  logic [rv32i_pkg::xlen-1:0] imem_rdata_i,
   output logic                       valid_o,
   output logic [rv32i_pkg::xlen-1:0] pc_o,
   output logic [rv32i_pkg::xlen-1:0] instr_o
);

   logic [rv32i_pkg::xlen-1:0] pc_q;

   assign imem_addr_o = pc_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         pc_q    <= rv32i_pkg::reset_pc;
         valid_o <= 1'b0;
      end else begin
         if (pcmux_sel_i) begin
            pc_q <= branch_target_i;
         end else begin
            pc_q <= pc_q + 32'd4;
         end
         // the word fetched alongside a redirect is on the wrong path
         valid_o <= !pcmux_sel_i;
      end
   end

   // fetch/decode payload
   always_ff @(posedge clk) begin
      pc_o    <= pc_q;
      instr_o <= imem_rdata_i;
   end

endmodule

/* design/rv32i_pkg.sv */
package rv32i_pkg;

   localparam int xlen = 32;

   localparam logic [xlen-1:0] reset_pc = '0;

   // branch conditions carried in funct3
   localparam logic [2:0] funct3_beq = 3'b000;
   localparam logic [2:0] funct3_bne = 3'b001;

   // major opcodes, only the supported subset
   typedef enum logic [6:0] {
      op_lui   = 7'b0110111,
      op_imm   = 7'b0010011,
      op_reg   = 7'b0110011,
      op_load  = 7'b0000011,
      op_store = 7'b0100011,
      op_br    = 7'b1100011
   } opcode_e;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_slt,
      alu_pass_b
   } alu_op_e;

endpackage
